//--- testbench/notchPatterns.hex
// one 32-bit hex word per entry: a1 a2 b0 b1 b2 (scaled by 2^14), run 1 inputs,
// run 1 filtered outputs, run 2 inputs, run 2 bypass outputs, 16 words per block
// coefficients a1 a2 b0 b1 b2
ffffe000 00001000 00004000 ffffc000 00002000
// run 1 input samples
000003e8 000007d0 fffffe0c 00000bb8 00000000 fffffa24 000002bc 000000fa
fffff060 000004b0 00000384 ffffff9c 0001e240 fffff63c 0000012c 00000040
// run 1 expected filtered outputs
000003e8 000005dc fffffa24 00000d2f fffffb5c fffffa62 000006f2 00000030
ffffef1f 00000c50 00000164 fffffc0e 0001e214 ffff05d0 00000673 00003bf7
// run 2 input samples
13579bdf 2468ace0 7fffffff 80000000 00000001 ffffffff 0f0f0f0f f0f0f0f0
12345678 87654321 55aa55aa aa55aa55 00010000 fffe0001 3c3c3c3c c3c3c3c3
// run 2 expected bypass outputs
13579bdf 2468ace0 7fffffff 80000000 00000001 ffffffff 0f0f0f0f f0f0f0f0
12345678 87654321 55aa55aa aa55aa55 00010000 fffe0001 3c3c3c3c c3c3c3c3

//--- vlog.f
rtl/notchPkg.sv
rtl/sampleFifo.sv
rtl/sdReader.sv
rtl/sdWriter.sv
rtl/sdArbiter.sv
rtl/biquadCore.sv
rtl/notchControl.sv
rtl/notchTop.sv
testbench/notchBind_sva.sv
testbench/notchTb.sv

//--- run.sh
#!/bin/sh
# build the notch filter testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module notchTb -f vlog.f -o notchSim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/notchSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "simulation ended without a pass message"
	exit 1
fi
exit 0

//--- testbench/notchTb.sv
// notchTb: clock, reset, pattern loading, sdram model with random waitrequest, test sequence, checks
`default_nettype none
`timescale 1ns/1ps

module notchTb import notchPkg::*; ();
	localparam int numSamples = 16;
	localparam int memWords = 256; // model spans byte addresses below 1 KiB
	localparam int patWords = 69;
	localparam int pIn1 = 5; // run 1 samples in the pattern array
	localparam int pExp1 = 21; // run 1 filtered results
	localparam int pIn2 = 37; // run 2 samples
	localparam int pExp2 = 53; // run 2 bypass results
	localparam logic [addrW-1:0] base1 = 24'h000100; // word 64
	localparam logic [addrW-1:0] base2 = 24'h000180; // word 96
	localparam int runTimeout = 4000; // cycles allowed per block
	localparam logic [3:0] coeffAddr [5] = '{csrA1, csrA2, csrB0, csrB1, csrB2};

	logic clk = 1'b0;
	logic rstN;
	logic ciStart;
	logic [31:0] ciDataA;
	logic csrRead;
	logic csrWrite;
	logic [3:0] csrAddress;
	logic [31:0] csrWriteData;
	logic sdWaitrequest = 1'b0; // driven by the sdram model
	logic sdReadDataValid = 1'b0;
	logic [sampleW-1:0] sdReadData = '0;
	logic ciDone;
	logic [31:0] ciResult;
	logic [31:0] csrReadData;
	logic [addrW-1:0] sdAddress;
	logic sdRead;
	logic sdWrite;
	logic [sampleW-1:0] sdWriteData;
	logic irq;

	logic [31:0] pat [patWords]; // coefficients, samples, expected words
	logic [31:0] mem [memWords]; // sdram contents
	logic [31:0] rngState = 32'h69d8;
	int cycle = 0; // falling edges since reset release
	logic [31:0] rdDataQ [$]; // read words on their way back
	int rdDueQ [$]; // cycle each one is returned

	always #4 clk = ~clk; // 8 ns period

	notchTop #(.numSamples(numSamples), .fifoDepth(16)) i_notchTop (
		.clk(clk), .rstN(rstN), .ciStart(ciStart), .ciDataA(ciDataA), .ciDone(ciDone),
		.ciResult(ciResult), .csrRead(csrRead), .csrWrite(csrWrite),
		.csrAddress(csrAddress), .csrWriteData(csrWriteData), .csrReadData(csrReadData),
		.sdAddress(sdAddress), .sdRead(sdRead), .sdWrite(sdWrite),
		.sdWriteData(sdWriteData), .sdReadData(sdReadData),
		.sdReadDataValid(sdReadDataValid), .sdWaitrequest(sdWaitrequest), .irq(irq));

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] fillWord(input int idx);
		return 32'h5a5a_0000 | 32'(idx); // tagged with the word address
	endfunction

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] expected, input string msg);
		if (got !== expected)
			stopWithFailure($sformatf("CHECK FAILED at time %0t: %s (got %h, expected %h)",
				$time, msg, got, expected));
	endtask

	// start strobe with the reply sampled one cycle later
	task automatic issueStart(input logic [31:0] addr, output logic [31:0] result);
		ciStart = 1'b1;
		ciDataA = addr;
		@(negedge clk);
		ciStart = 1'b0;
		ciDataA = '0;
		check({31'b0, ciDone}, 32'd1, "ciDone one cycle after start");
		result = ciResult;
		@(negedge clk);
	endtask

	task automatic csrWriteWord(input logic [3:0] addr, input logic [31:0] data);
		csrWrite = 1'b1;
		csrAddress = addr;
		csrWriteData = data;
		@(negedge clk);
		csrWrite = 1'b0;
	endtask

	task automatic csrReadWord(input logic [3:0] addr, output logic [31:0] data);
		csrRead = 1'b1;
		csrAddress = addr;
		@(negedge clk);
		csrRead = 1'b0;
		data = csrReadData; // valid after the sampling edge
	endtask

	// status polls while the block runs
	task automatic pollUntilIrq(input string runName);
		int waited;
		logic [31:0] last;
		logic [31:0] progress;
		waited = 0;
		last = '0;
		while (!irq) begin
			if (waited > runTimeout)
				stopWithFailure($sformatf("TIMEOUT: %s saw no irq within %0d cycles",
					runName, runTimeout));
			issueStart('0, progress);
			check({31'b0, progress >= last}, 32'd1, "progress never decreases");
			check({31'b0, progress <= 32'(numSamples)}, 32'd1, "progress within block");
			last = progress;
			repeat (3) @(negedge clk); // spacing between polls
			waited += 5;
		end
	endtask

	task automatic checkBlock(input logic [addrW-1:0] base, input int expOffset,
		input string runName);
		int first;
		first = int'(base[9:2]);
		for (int i = 0; i < numSamples; i++)
			check(mem[first + i], pat[expOffset + i], $sformatf("%s word %0d", runName, i));
		check(mem[first - 1], fillWord(first - 1), $sformatf("%s word below block", runName));
		check(mem[first + numSamples], fillWord(first + numSamples),
			$sformatf("%s word above block", runName));
	endtask

	// sdram model deciding the coming edge's handshake on the falling edge
	always @(negedge clk) begin
		int idx;
		int due;
		if (!rstN) begin
			for (int i = 0; i < memWords; i++)
				mem[i] = fillWord(i);
			for (int i = 0; i < numSamples; i++) begin
				mem[int'(base1[9:2]) + i] = pat[pIn1 + i];
				mem[int'(base2[9:2]) + i] = pat[pIn2 + i];
			end
			sdWaitrequest = 1'b0;
			sdReadDataValid = 1'b0;
		end else begin
			cycle++;
			rngState = xorshift32(rngState);
			sdWaitrequest = (rngState[2:0] < 3'd3); // about three stalls in eight
			idx = int'(sdAddress[9:2]);
			if ((sdRead || sdWrite) && !sdWaitrequest)
				check(32'(sdAddress[addrW-1:10]), 32'd0, "sdram address inside model");
			if (sdRead && !sdWaitrequest) begin
				due = cycle + 1 + int'(rngState[9:8]) % 3; // 1 to 3 cycles
				if (rdDueQ.size() > 0 && due <= rdDueQ[rdDueQ.size() - 1])
					due = rdDueQ[rdDueQ.size() - 1] + 1; // keeps returns in order
				rdDataQ.push_back(mem[idx]);
				rdDueQ.push_back(due);
			end
			if (sdWrite && !sdWaitrequest)
				mem[idx] = sdWriteData;
			if (rdDueQ.size() > 0 && rdDueQ[0] <= cycle) begin
				sdReadDataValid = 1'b1;
				sdReadData = rdDataQ.pop_front();
				void'(rdDueQ.pop_front());
			end else begin
				sdReadDataValid = 1'b0;
			end
		end
	end

	initial begin
		logic [31:0] result;
		logic [31:0] readBack;
		rstN = 1'b0;
		ciStart = 1'b0;
		ciDataA = '0;
		csrRead = 1'b0;
		csrWrite = 1'b0;
		csrAddress = '0;
		csrWriteData = '0;
		$readmemh("testbench/notchPatterns.hex", pat);
		repeat (4) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);

		issueStart('0, result); // zero address in idle is a poll
		check(result, ciIdle, "zero-address start in idle");

		for (int i = 0; i < 5; i++) begin
			csrWriteWord(coeffAddr[i], pat[i]);
			csrReadWord(coeffAddr[i], readBack);
			check(readBack, pat[i], $sformatf("coefficient %0d read back", i));
		end
		csrWriteWord(csrCtrl, 32'd1);
		csrReadWord(csrCtrl, readBack);
		check(readBack, 32'd1, "bypass set read back");
		csrWriteWord(csrCtrl, 32'd0);
		csrReadWord(csrCtrl, readBack);
		check(readBack, 32'd0, "bypass cleared read back");

		issueStart(32'(base1), result); // filtered block
		check(result, ciAccepted, "run 1 start accepted");
		pollUntilIrq("run 1");
		issueStart('0, result);
		check(result, ciFinished, "start after run 1 irq");
		checkBlock(base1, pExp1, "run 1");
		csrReadWord(csrReceived, readBack); // also services irq
		check(readBack, 32'(numSamples), "received count after run 1");
		check({31'b0, irq}, 32'd0, "irq cleared by csr read");
		issueStart('0, result);
		check(result, ciIdle, "idle after irq service");

		csrWriteWord(csrCtrl, 32'd1); // bypass block
		issueStart(32'(base2), result);
		check(result, ciAccepted, "run 2 start accepted");
		pollUntilIrq("run 2");
		issueStart('0, result);
		check(result, ciFinished, "start after run 2 irq");
		checkBlock(base2, pExp2, "run 2");
		csrReadWord(csrWritten, readBack);
		check(readBack, 32'(numSamples), "written count after run 2");
		check({31'b0, irq}, 32'd0, "irq cleared after run 2");

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/notchBind_sva.sv
// notchBusAssertions: ciDone width, single bus request, stall stability, irq in reset, bind to notchTop
`default_nettype none
`timescale 1ns/1ps

module notchBusAssertions import notchPkg::*; (
	input wire clk,
	input wire rstN,
	input wire ciDone,
	input wire irq,
	input wire sdRead,
	input wire sdWrite,
	input wire sdWaitrequest,
	input wire [addrW-1:0] sdAddress,
	input wire [sampleW-1:0] sdWriteData
);
	ciDonePulse: assert property (@(posedge clk) disable iff (!rstN) ciDone |=> !ciDone)
		else $error("ciDone held longer than one cycle");
	oneRequest: assert property (@(posedge clk) disable iff (!rstN) !(sdRead && sdWrite))
		else $error("read and write requested together");
	stalledRead: assert property (@(posedge clk) disable iff (!rstN)
		sdRead && sdWaitrequest |=> sdRead && $stable(sdAddress)) // held until taken
		else $error("stalled read changed before acceptance");
	stalledWrite: assert property (@(posedge clk) disable iff (!rstN)
		sdWrite && sdWaitrequest |=> sdWrite && $stable(sdAddress) && $stable(sdWriteData))
		else $error("stalled write changed before acceptance");
	irqInReset: assert property (@(posedge clk) !rstN |=> !irq)
		else $error("irq high during reset");
endmodule

bind notchTop notchBusAssertions i_busAssertions (
	.clk(clk), .rstN(rstN), .ciDone(ciDone), .irq(irq), .sdRead(sdRead),
	.sdWrite(sdWrite), .sdWaitrequest(sdWaitrequest), .sdAddress(sdAddress),
	.sdWriteData(sdWriteData));

`default_nettype wire

//--- rtl/notchTop.sv
// notchTop: control, reader, writer, arbiter, read and result FIFOs and biquad core
`default_nettype none
`timescale 1ns/1ps

module notchTop import notchPkg::*; #(
	parameter int numSamples = 16,
	parameter int fifoDepth = 16
) (
	input wire clk,
	input wire rstN,
	input wire ciStart,
	input wire [31:0] ciDataA,
	output logic ciDone,
	output logic [31:0] ciResult,
	input wire csrRead,
	input wire csrWrite,
	input wire [3:0] csrAddress,
	input wire csrWord csrWriteData,
	output logic [31:0] csrReadData,
	output logic [addrW-1:0] sdAddress,
	output logic sdRead,
	output logic sdWrite,
	output logic [sampleW-1:0] sdWriteData,
	input wire [sampleW-1:0] sdReadData,
	input wire sdReadDataValid,
	input wire sdWaitrequest,
	output logic irq
);
	localparam int levelW = $clog2(fifoDepth + 1);

	logic runStart, clearAll, bypass, blockDone;
	logic [addrW-1:0] baseAddr;
	logic signed [coeffW-1:0] a1, a2, b0, b1, b2;
	logic rdReq, rdAccept, wrReq, wrAccept;
	logic [addrW-1:0] rdAddr, wrAddr;
	logic [sampleW-1:0] wrData;
	logic [31:0] writtenCount, receivedCount;
	logic inPop, inEmpty, outPush, outFull, resPop, resEmpty;
	logic [sampleW-1:0] inData, outData, resData;
	logic [levelW-1:0] readLevel; // bounds the reader's outstanding requests

	notchControl #(.numSamples(numSamples)) i_notchControl (
		.clk(clk), .rstN(rstN), .ciStart(ciStart), .ciDataA(ciDataA),
		.csrRead(csrRead), .csrWrite(csrWrite), .csrAddress(csrAddress),
		.csrWriteData(csrWriteData), .writtenCount(writtenCount),
		.receivedCount(receivedCount), .blockDone(blockDone), .ciDone(ciDone),
		.ciResult(ciResult), .csrReadData(csrReadData), .irq(irq), .runStart(runStart),
		.baseAddr(baseAddr), .clearAll(clearAll), .bypass(bypass),
		.a1(a1), .a2(a2), .b0(b0), .b1(b1), .b2(b2));

	sdReader #(.numSamples(numSamples), .fifoDepth(fifoDepth)) i_sdReader (
		.clk(clk), .rstN(rstN), .runStart(runStart), .clearAll(clearAll),
		.baseAddr(baseAddr), .rdAccept(rdAccept), .sdReadDataValid(sdReadDataValid),
		.fifoLevel(readLevel), .rdReq(rdReq), .rdAddr(rdAddr),
		.receivedCount(receivedCount));

	sdWriter #(.numSamples(numSamples)) i_sdWriter (
		.clk(clk), .rstN(rstN), .runStart(runStart), .clearAll(clearAll),
		.baseAddr(baseAddr), .resEmpty(resEmpty), .resData(resData), .wrAccept(wrAccept),
		.resPop(resPop), .wrReq(wrReq), .wrAddr(wrAddr), .wrData(wrData),
		.writtenCount(writtenCount), .blockDone(blockDone));

	sdArbiter i_sdArbiter (
		.clk(clk), .rstN(rstN), .rdReq(rdReq), .rdAddr(rdAddr), .wrReq(wrReq),
		.wrAddr(wrAddr), .wrData(wrData), .sdWaitrequest(sdWaitrequest),
		.rdAccept(rdAccept), .wrAccept(wrAccept), .sdAddress(sdAddress),
		.sdRead(sdRead), .sdWrite(sdWrite), .sdWriteData(sdWriteData));

	sampleFifo #(.fifoDepth(fifoDepth)) readFifo ( // returning sdram words
		.clk(clk), .rstN(rstN), .clear(clearAll), .push(sdReadDataValid),
		.pushData(sdReadData), .pop(inPop), .popData(inData), .empty(inEmpty),
		.full(), .level(readLevel));

	sampleFifo #(.fifoDepth(fifoDepth)) resultFifo ( // filtered words to the writer
		.clk(clk), .rstN(rstN), .clear(clearAll), .push(outPush),
		.pushData(outData), .pop(resPop), .popData(resData), .empty(resEmpty),
		.full(outFull), .level());

	biquadCore i_biquadCore (
		.clk(clk), .rstN(rstN), .clearAll(clearAll), .inEmpty(inEmpty), .inData(inData),
		.outFull(outFull), .bypass(bypass), .a1(a1), .a2(a2), .b0(b0), .b1(b1), .b2(b2),
		.inPop(inPop), .outPush(outPush), .outData(outData));

endmodule

`default_nettype wire

//--- rtl/notchControl.sv
// notchControl: run FSM, custom-instruction replies, coefficient and bypass registers, CSR reads, irq
`default_nettype none
`timescale 1ns/1ps

module notchControl import notchPkg::*; #(
	parameter int numSamples = 16
) (
	input wire clk,
	input wire rstN,
	input wire ciStart,
	input wire [31:0] ciDataA, // base address, or zero for a status poll
	input wire csrRead,
	input wire csrWrite,
	input wire [3:0] csrAddress,
	input wire csrWord csrWriteData,
	input wire [31:0] writtenCount,
	input wire [31:0] receivedCount,
	input wire blockDone,
	output logic ciDone,
	output logic [31:0] ciResult,
	output logic [31:0] csrReadData,
	output logic irq,
	output logic runStart,
	output logic [addrW-1:0] baseAddr,
	output logic clearAll,
	output logic bypass,
	output logic signed [coeffW-1:0] a1,
	output logic signed [coeffW-1:0] a2,
	output logic signed [coeffW-1:0] b0,
	output logic signed [coeffW-1:0] b1,
	output logic signed [coeffW-1:0] b2
);
	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stRun = 2'd1;
	localparam logic [1:0] stDone = 2'd2; // irq raised until a csr read

	logic [1:0] state;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
			ciDone <= 1'b0;
			ciResult <= '0;
			irq <= 1'b0;
			runStart <= 1'b0;
			clearAll <= 1'b0;
			baseAddr <= '0;
		end else begin
			ciDone <= ciStart; // reply one cycle after the strobe
			runStart <= 1'b0;
			clearAll <= 1'b0;
			case (state)
				stIdle: begin
					if (ciStart && ciDataA != '0) begin
						ciResult <= ciAccepted;
						baseAddr <= ciDataA[addrW-1:0];
						runStart <= 1'b1;
						state <= stRun;
					end else if (ciStart) begin
						ciResult <= ciIdle;
					end
				end
				stRun: begin
					if (ciStart) ciResult <= writtenCount; // words written so far
					if (blockDone) begin
						irq <= 1'b1;
						state <= stDone;
					end
				end
				default: begin
					if (ciStart) ciResult <= ciFinished;
					if (csrRead) begin // any read services the interrupt
						irq <= 1'b0;
						clearAll <= 1'b1;
						state <= stIdle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			bypass <= 1'b0;
			a1 <= defA1;
			a2 <= defA2;
			b0 <= defB0;
			b1 <= defB1;
			b2 <= defB2;
		end else if (csrWrite) begin
			case (csrAddress)
				csrCtrl: bypass <= csrWriteData.ctrl.bypass;
				csrA1: a1 <= csrWriteData.coeff.value;
				csrA2: a2 <= csrWriteData.coeff.value;
				csrB0: b0 <= csrWriteData.coeff.value;
				csrB1: b1 <= csrWriteData.coeff.value;
				csrB2: b2 <= csrWriteData.coeff.value;
				default: ; // counters are read only
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (csrRead) begin
			case (csrAddress)
				csrCtrl: csrReadData <= {31'b0, bypass};
				csrA1: csrReadData <= 32'(a1); // sign extended
				csrA2: csrReadData <= 32'(a2);
				csrB0: csrReadData <= 32'(b0);
				csrB1: csrReadData <= 32'(b1);
				csrB2: csrReadData <= 32'(b2);
				csrWritten: csrReadData <= writtenCount;
				csrReceived: csrReadData <= receivedCount;
				default: csrReadData <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/biquadCore.sv
// biquadCore: recursive biquad datapath, x and y history, products, sums, scaling and push
`default_nettype none
`timescale 1ns/1ps

module biquadCore import notchPkg::*; (
	input wire clk,
	input wire rstN,
	input wire clearAll,
	input wire inEmpty,
	input wire [sampleW-1:0] inData, // read fifo head
	input wire outFull,
	input wire bypass,
	input wire signed [coeffW-1:0] a1,
	input wire signed [coeffW-1:0] a2,
	input wire signed [coeffW-1:0] b0,
	input wire signed [coeffW-1:0] b1,
	input wire signed [coeffW-1:0] b2,
	output logic inPop,
	output logic outPush,
	output logic [sampleW-1:0] outData
);
	logic [3:0] step; // 0 pop .. 8 push
	logic [sampleW-1:0] xIn; // sample taken at the pop
	logic signed [sampleW-1:0] xN; // x(n)
	logic signed [sampleW-1:0] xN1; // x(n-1)
	logic signed [sampleW-1:0] xN2; // x(n-2)
	logic signed [sampleW-1:0] yN1; // y(n-1)
	logic signed [sampleW-1:0] yN2; // y(n-2)
	logic signed [sampleW-1:0] yNew; // scaled result before it joins the history
	logic signed [prodW-1:0] pB0, pB1, pB2, pA1, pA2;
	logic signed [accW-1:0] sumB; // b0 and b1 terms
	logic signed [accW-1:0] sumC; // b2 term less a1 term
	logic signed [accW-1:0] sumD; // a2 term, subtracted last
	logic signed [accW-1:0] acc;

	assign inPop = (step == 4'd0) && !inEmpty;
	assign outPush = (step == 4'd8) && !outFull; // full result fifo stalls here

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			step <= '0;
			xN <= '0;
			xN1 <= '0;
			xN2 <= '0;
			yN1 <= '0;
			yN2 <= '0;
		end else if (clearAll) begin
			step <= '0;
			xN <= '0;
			xN1 <= '0;
			xN2 <= '0;
			yN1 <= '0;
			yN2 <= '0;
		end else begin
			case (step)
				4'd0: if (inPop) step <= 4'd1;
				4'd1: begin // capture x, shift history
					xN <= xIn;
					xN1 <= xN;
					xN2 <= xN1;
					step <= 4'd2;
				end
				4'd6: begin // y history follows even in bypass
					yN1 <= yNew;
					yN2 <= yN1;
					step <= 4'd7;
				end
				4'd8: if (outPush) step <= 4'd0;
				default: step <= step + 4'd1;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (step)
			4'd0: xIn <= inData;
			4'd2: begin
				pB0 <= prodW'(xN) * prodW'(b0);
				pB1 <= prodW'(xN1) * prodW'(b1);
				pB2 <= prodW'(xN2) * prodW'(b2);
				pA1 <= prodW'(yN1) * prodW'(a1);
				pA2 <= prodW'(yN2) * prodW'(a2);
			end
			4'd3: begin // partial sums, sign extended
				sumB <= accW'(pB0) + accW'(pB1);
				sumC <= accW'(pB2) - accW'(pA1);
				sumD <= accW'(pA2);
			end
			4'd4: acc <= sumB + sumC - sumD;
			4'd5: yNew <= acc[coeffShift +: sampleW]; // arithmetic >>> 14, low word
			4'd7: outData <= bypass ? xN : yN1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/sdArbiter.sv
// sdArbiter: single sdram master port shared by reader and writer, read first, grant held on stall
`default_nettype none
`timescale 1ns/1ps

module sdArbiter import notchPkg::*; (
	input wire clk,
	input wire rstN,
	input wire rdReq,
	input wire [addrW-1:0] rdAddr,
	input wire wrReq,
	input wire [addrW-1:0] wrAddr,
	input wire [sampleW-1:0] wrData,
	input wire sdWaitrequest,
	output logic rdAccept,
	output logic wrAccept,
	output logic [addrW-1:0] sdAddress,
	output logic sdRead,
	output logic sdWrite,
	output logic [sampleW-1:0] sdWriteData
);
	logic busy; // a request is stalled on the bus
	logic ownerWr; // owner of the stalled request
	logic selWr; // writer has the port this cycle
	logic onBus;

	// free port goes to the reader when it asks, stalled port keeps its owner
	assign selWr = busy ? ownerWr : !rdReq;
	assign sdRead = !selWr && rdReq;
	assign sdWrite = selWr && wrReq;
	assign sdAddress = selWr ? wrAddr : rdAddr;
	assign sdWriteData = wrData;
	assign onBus = sdRead || sdWrite;
	assign rdAccept = sdRead && !sdWaitrequest;
	assign wrAccept = sdWrite && !sdWaitrequest;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			ownerWr <= 1'b0;
		end else begin
			busy <= onBus && sdWaitrequest; // drops on the accepting edge
			if (onBus && sdWaitrequest) ownerWr <= selWr;
		end
	end

endmodule

`default_nettype wire

//--- rtl/sdWriter.sv
// sdWriter: result FIFO drain into sdram writes at ascending addresses, written count
`default_nettype none
`timescale 1ns/1ps

module sdWriter import notchPkg::*; #(
	parameter int numSamples = 16
) (
	input wire clk,
	input wire rstN,
	input wire runStart,
	input wire clearAll,
	input wire [addrW-1:0] baseAddr,
	input wire resEmpty,
	input wire [sampleW-1:0] resData,
	input wire wrAccept, // write taken by the sdram
	output logic resPop,
	output logic wrReq,
	output logic [addrW-1:0] wrAddr,
	output logic [sampleW-1:0] wrData,
	output logic [31:0] writtenCount,
	output logic blockDone
);
	logic active; // block in progress

	// next result may be taken once the slot is free or being freed
	assign resPop = active && !resEmpty && (!wrReq || wrAccept);
	assign blockDone = (writtenCount == 32'(numSamples));

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			active <= 1'b0;
			wrReq <= 1'b0;
			wrAddr <= '0;
			writtenCount <= '0;
		end else if (clearAll) begin
			active <= 1'b0;
			wrReq <= 1'b0;
			writtenCount <= '0;
		end else if (runStart) begin
			active <= 1'b1;
			wrAddr <= baseAddr; // results overwrite their samples
			writtenCount <= '0;
		end else begin
			if (wrAccept) begin
				wrAddr <= wrAddr + addrW'(wordSkip);
				writtenCount <= writtenCount + 32'd1;
			end
			if (resPop) wrReq <= 1'b1;
			else if (wrAccept) wrReq <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (resPop) wrData <= resData; // held until accepted
	end

endmodule

`default_nettype wire

//--- rtl/sdReader.sv
// sdReader: sample read requests, outstanding-read limit against read FIFO space, received count
`default_nettype none
`timescale 1ns/1ps

module sdReader import notchPkg::*; #(
	parameter int numSamples = 16,
	parameter int fifoDepth = 16
) (
	input wire clk,
	input wire rstN,
	input wire runStart,
	input wire clearAll,
	input wire [addrW-1:0] baseAddr,
	input wire rdAccept, // read taken by the sdram
	input wire sdReadDataValid,
	input wire [$clog2(fifoDepth + 1) - 1:0] fifoLevel,
	output logic rdReq,
	output logic [addrW-1:0] rdAddr,
	output logic [31:0] receivedCount
);
	localparam int levelW = $clog2(fifoDepth + 1);

	logic active; // block in progress
	logic [31:0] issuedCount; // reads accepted so far
	logic [levelW-1:0] outstanding; // accepted, data not back yet
	logic [levelW:0] inFlight; // outstanding plus words queued

	assign inFlight = {1'b0, outstanding} + {1'b0, fifoLevel};
	// sum only grows on accept, so a raised request holds until taken
	assign rdReq = active && (issuedCount < 32'(numSamples))
		&& (inFlight < (levelW + 1)'(fifoDepth));

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			active <= 1'b0;
			rdAddr <= '0;
			issuedCount <= '0;
			outstanding <= '0;
			receivedCount <= '0;
		end else if (clearAll) begin
			active <= 1'b0;
			issuedCount <= '0;
			outstanding <= '0;
			receivedCount <= '0;
		end else if (runStart) begin
			active <= 1'b1;
			rdAddr <= baseAddr; // first sample
			issuedCount <= '0;
			outstanding <= '0;
			receivedCount <= '0;
		end else begin
			if (rdAccept) begin
				rdAddr <= rdAddr + addrW'(wordSkip);
				issuedCount <= issuedCount + 32'd1;
			end
			if (rdAccept && !sdReadDataValid) outstanding <= outstanding + 1'b1;
			else if (sdReadDataValid && !rdAccept) outstanding <= outstanding - 1'b1;
			if (sdReadDataValid) receivedCount <= receivedCount + 32'd1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/sampleFifo.sv
// sampleFifo: circular buffer with clear, level count and show-ahead head word
`default_nettype none
`timescale 1ns/1ps

module sampleFifo import notchPkg::*; #(
	parameter int fifoDepth = 16
) (
	input wire clk,
	input wire rstN,
	input wire clear, // drop everything and send the pointers home
	input wire push,
	input wire [sampleW-1:0] pushData,
	input wire pop,
	output logic [sampleW-1:0] popData,
	output logic empty,
	output logic full,
	output logic [$clog2(fifoDepth + 1) - 1:0] level
);
	localparam int levelW = $clog2(fifoDepth + 1);
	localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;

	logic [sampleW-1:0] mem [fifoDepth]; // word storage
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic doPush; // push that fits
	logic doPop; // pop of a real word

	function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
		return (ptr == ptrW'(fifoDepth - 1)) ? '0 : ptr + 1'b1; // wrap at depth
	endfunction

	assign doPush = push && !full;
	assign doPop = pop && !empty;
	assign empty = (level == '0);
	assign full = (level == levelW'(fifoDepth));
	assign popData = mem[rdPtr]; // head word shown ahead of the pop

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end else if (clear) begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end else begin
			if (doPush) wrPtr <= nextPtr(wrPtr);
			if (doPop) rdPtr <= nextPtr(rdPtr);
			if (doPush && !doPop) level <= level + 1'b1;
			else if (doPop && !doPush) level <= level - 1'b1; // both at once keeps level
		end
	end

	always_ff @(posedge clk) begin
		if (doPush) mem[wrPtr] <= pushData;
	end

endmodule

`default_nettype wire

//--- rtl/notchPkg.sv
// widths, fixed-point scale, coefficient defaults, CSR map, instruction codes and CSR write word
`default_nettype none

package notchPkg;

	localparam int sampleW = 32; // sample and result word
	localparam int coeffW = 16; // signed coefficient
	localparam int prodW = 48; // sample times coefficient
	localparam int accW = 64; // accumulator, room for five products
	localparam int addrW = 24; // sdram byte address
	localparam int coeffShift = 14; // coefficients scaled by 2^14
	localparam int wordSkip = 4; // bytes between samples

	// reset coefficients for a notch near the low end of the band
	localparam logic signed [coeffW-1:0] defA1 = -16'sd31037;
	localparam logic signed [coeffW-1:0] defA2 = 16'sd14971;
	localparam logic signed [coeffW-1:0] defB0 = 16'sd8276;
	localparam logic signed [coeffW-1:0] defB1 = -16'sd16384;
	localparam logic signed [coeffW-1:0] defB2 = 16'sd8276;

	localparam logic [3:0] csrCtrl = 4'd0; // bypass in bit 0
	localparam logic [3:0] csrA1 = 4'd1;
	localparam logic [3:0] csrA2 = 4'd2;
	localparam logic [3:0] csrB0 = 4'd3;
	localparam logic [3:0] csrB1 = 4'd4;
	localparam logic [3:0] csrB2 = 4'd5;
	localparam logic [3:0] csrWritten = 4'd6; // read only
	localparam logic [3:0] csrReceived = 4'd7; // read only

	localparam logic [31:0] ciAccepted = 32'd99; // run started
	localparam logic [31:0] ciIdle = 32'hffff_ffff; // nothing running
	localparam logic [31:0] ciFinished = 32'd2; // waiting for irq service

	// one csr write word read as control bits or as a coefficient
	typedef union packed {
		struct packed {
			logic [sampleW-2:0] rsvd;
			logic bypass; // pass samples through unfiltered
		} ctrl;
		struct packed {
			logic [sampleW-coeffW-1:0] rsvd;
			logic signed [coeffW-1:0] value;
		} coeff;
	} csrWord;

endpackage

`default_nettype wire
